// File: src/ma_pkg.sv
// memory access package, shared command, writeback and request types with the region constants
package ma_pkg;

	// top two address bits that select the I/O bank
	localparam logic [1:0] IO_REGION = 2'b11;

	// 16 I/O word registers
	localparam int IO_ADR_BITS = 4;

	// data RAM of 256 words
	localparam int MEM_ADR_BITS = 8;

	// minimum memory wait, addr[3:2] adds to it
	localparam int MEM_BASE_WAIT = 2;

	typedef enum logic [1:0] {
		OP_LOAD  = 2'b00,
		OP_STORE = 2'b01,
		OP_PASS  = 2'b10
	} ma_op_e;

	// same coding as funct3[1:0]
	typedef enum logic [1:0] {
		SZ_BYTE = 2'b00,
		SZ_HALF = 2'b01,
		SZ_WORD = 2'b10
	} ma_size_e;

	// bit 2 marks the I/O side
	typedef enum logic [2:0] {
		ST_IDLE      = 3'b000,
		ST_MEM_READ  = 3'b001,
		ST_MEM_WRITE = 3'b010,
		ST_IO_READ1  = 3'b101,
		ST_IO_READ2  = 3'b111,
		ST_IO_WRITE  = 3'b110
	} ma_state_e;

	typedef struct packed {
		ma_op_e      op;
		ma_size_e    size;
		logic [4:0]  rd_adr;
		// address for load or store, result for pass
		logic [31:0] addr;
		logic [31:0] st_data;
	} ma_cmd_t;

	typedef struct packed {
		logic [4:0]  rd_adr;
		logic [31:0] data;
	} wb_t;

	typedef struct packed {
		logic        write;
		ma_size_e    size;
		logic [31:0] addr;
		logic [31:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic [IO_ADR_BITS-1:0] idx;
		logic [31:0]            wdata;
	} io_req_t;

endpackage

// File: src/ma_access_stage.sv
// memory access stage, decodes the region, sequences the access and returns the writeback
`timescale 1ns/1ns

module ma_access_stage (
	input  logic               clk,
	input  logic               rst_n,

	// from execute
	input  logic               cmd_valid,
	input  ma_pkg::ma_cmd_t    cmd,

	// data memory controller
	output logic               mem_req_valid,
	output ma_pkg::mem_req_t   mem_req,
	input  logic               mem_done,
	input  logic [31:0]        mem_rdata,

	// I/O bank
	output logic               io_we,
	output logic               io_re,
	output ma_pkg::io_req_t    io_req,
	input  logic [31:0]        io_rdata,

	// register file and sequencer
	output logic               wb_valid,
	output ma_pkg::wb_t        wb,
	output logic               busy
);

	ma_pkg::ma_state_e state;
	ma_pkg::ma_state_e next_state;
	logic              accept;
	logic              sel_io;
	logic              is_load;
	logic              is_store;
	logic              is_pass;
	logic [4:0]        rd_adr_q;
	logic              wb_load;
	logic [4:0]        wb_rd_sel;
	logic [31:0]       wb_data_sel;

	// commands while busy are dropped
	assign accept   = cmd_valid & (state == ma_pkg::ST_IDLE);
	assign sel_io   = (cmd.addr[31:30] == ma_pkg::IO_REGION);
	assign is_load  = (cmd.op == ma_pkg::OP_LOAD);
	assign is_store = (cmd.op == ma_pkg::OP_STORE);
	assign is_pass  = (cmd.op == ma_pkg::OP_PASS);

	// request strobes go out in the command cycle
	assign mem_req_valid = accept & ~sel_io & (is_load | is_store);
	assign io_we         = accept & sel_io & is_store;
	assign io_re         = accept & sel_io & is_load;

	assign mem_req.write = is_store;
	assign mem_req.size  = cmd.size;
	assign mem_req.addr  = cmd.addr;
	assign mem_req.wdata = cmd.st_data;

	// word index only, I/O has no byte lanes
	assign io_req.idx   = cmd.addr[ma_pkg::IO_ADR_BITS+1:2];
	assign io_req.wdata = cmd.st_data;

	always_comb begin
		next_state = state;
		case (state)
			ma_pkg::ST_IDLE: begin
				if (accept & sel_io & is_load)
					next_state = ma_pkg::ST_IO_READ1;
				else if (accept & sel_io & is_store)
					next_state = ma_pkg::ST_IO_WRITE;
				else if (accept & is_load)
					next_state = ma_pkg::ST_MEM_READ;
				else if (accept & is_store)
					next_state = ma_pkg::ST_MEM_WRITE;
			end
			// stay one more cycle so busy covers the writeback
			ma_pkg::ST_MEM_READ: begin
				if (wb_valid)
					next_state = ma_pkg::ST_IDLE;
			end
			ma_pkg::ST_MEM_WRITE: begin
				if (mem_done)
					next_state = ma_pkg::ST_IDLE;
			end
			ma_pkg::ST_IO_READ1: next_state = ma_pkg::ST_IO_READ2;
			ma_pkg::ST_IO_READ2: next_state = ma_pkg::ST_IDLE;
			ma_pkg::ST_IO_WRITE: next_state = ma_pkg::ST_IDLE;
			default:             next_state = ma_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= ma_pkg::ST_IDLE;
		else
			state <= next_state;
	end

	assign busy = (state != ma_pkg::ST_IDLE);

	// destination register while the access is open
	always_ff @(posedge clk) begin
		if (accept)
			rd_adr_q <= cmd.rd_adr;
	end

	// writeback source select
	always_comb begin
		wb_load     = 1'b0;
		wb_rd_sel   = cmd.rd_adr;
		wb_data_sel = cmd.addr;
		case (state)
			ma_pkg::ST_IDLE: begin
				wb_load = accept & is_pass;
			end
			// io_rdata holds the word registered in the strobe cycle
			ma_pkg::ST_IO_READ1: begin
				wb_load     = 1'b1;
				wb_rd_sel   = rd_adr_q;
				wb_data_sel = io_rdata;
			end
			ma_pkg::ST_MEM_READ: begin
				wb_load     = mem_done;
				wb_rd_sel   = rd_adr_q;
				wb_data_sel = mem_rdata;
			end
			default: wb_load = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_valid <= 1'b0;
		else
			wb_valid <= wb_load;
	end

	always_ff @(posedge clk) begin
		if (wb_load) begin
			wb.rd_adr <= wb_rd_sel;
			wb.data   <= wb_data_sel;
		end
	end

endmodule

// File: src/data_mem_ctrl.sv
// data RAM controller with variable wait, byte lanes and zero-extended reads
`timescale 1ns/1ns

module data_mem_ctrl (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             req_valid,
	input  ma_pkg::mem_req_t req,
	output logic             done,
	output logic [31:0]      rdata
);

	logic [31:0]                    ram [2**ma_pkg::MEM_ADR_BITS];
	ma_pkg::mem_req_t               req_q;
	logic                           active;
	logic [2:0]                     cnt;
	logic                           fire;
	logic [ma_pkg::MEM_ADR_BITS-1:0] word_idx;
	logic [3:0]                     lane_en;
	logic [31:0]                    wdata_rep;

	// byte enables from size and offset
	function automatic logic [3:0] lanes(input ma_pkg::ma_size_e size, input logic [1:0] off);
		logic [3:0] en;
		case (size)
			ma_pkg::SZ_BYTE: en = 4'b0001 << off;
			ma_pkg::SZ_HALF: en = off[1] ? 4'b1100 : 4'b0011;
			default:         en = 4'b1111;
		endcase
		return en;
	endfunction

	// shift the lane down, upper bits zero
	function automatic logic [31:0] extract(input logic [31:0] word,
			input ma_pkg::ma_size_e size, input logic [1:0] off);
		logic [31:0] shifted;
		logic [31:0] res;
		shifted = word >> {off, 3'b000};
		case (size)
			ma_pkg::SZ_BYTE: res = {24'h000000, shifted[7:0]};
			ma_pkg::SZ_HALF: res = {16'h0000, shifted[15:0]};
			default:         res = shifted;
		endcase
		return res;
	endfunction

	assign fire     = active & (cnt == 3'd1);
	assign word_idx = req_q.addr[ma_pkg::MEM_ADR_BITS+1:2];
	assign lane_en  = lanes(req_q.size, req_q.addr[1:0]);

	// store data copied to every lane it may land in
	always_comb begin
		case (req_q.size)
			ma_pkg::SZ_BYTE: wdata_rep = {4{req_q.wdata[7:0]}};
			ma_pkg::SZ_HALF: wdata_rep = {2{req_q.wdata[15:0]}};
			default:         wdata_rep = req_q.wdata;
		endcase
	end

	// wait count, done lands MEM_BASE_WAIT + addr[3:2] cycles after the request
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			cnt    <= 3'd0;
			done   <= 1'b0;
		end else begin
			done <= fire;
			if (req_valid) begin
				active <= 1'b1;
				cnt    <= 3'(ma_pkg::MEM_BASE_WAIT - 1) + 3'(req.addr[3:2]);
			end else if (fire) begin
				active <= 1'b0;
			end else if (active) begin
				cnt <= cnt - 3'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid)
			req_q <= req;
	end

	// array access in the last wait cycle
	always_ff @(posedge clk) begin
		if (fire & req_q.write) begin
			for (int i = 0; i < 4; i++) begin
				if (lane_en[i])
					ram[word_idx][8*i +: 8] <= wdata_rep[8*i +: 8];
			end
		end
		if (fire & ~req_q.write)
			rdata <= extract(ram[word_idx], req_q.size, req_q.addr[1:0]);
	end

endmodule

// File: src/io_regs.sv
// I/O register bank, word writes and one-cycle registered reads
`timescale 1ns/1ns

module io_regs (
	input  logic            clk,
	input  logic            rst_n,

	// write strobe from the stage
	input  logic            we,

	// read strobe, data follows one cycle later
	input  logic            re,

	input  ma_pkg::io_req_t req,
	output logic [31:0]     rdata
);

	localparam int NUM_REGS = 2**ma_pkg::IO_ADR_BITS;

	logic [31:0] regs [NUM_REGS];

	// register file, all zero out of reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= 32'h0;
		end else if (we) begin
			regs[req.idx] <= req.wdata;
		end
	end

	// read port
	// held between reads so the stage can take it in io_read1
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rdata <= 32'h0;
		else if (re)
			rdata <= regs[req.idx];
	end

endmodule

// File: src/dmem_subsys.sv
// data access subsystem, the access stage with its data RAM controller and I/O bank
`timescale 1ns/1ns

module dmem_subsys (
	input  logic            clk,
	input  logic            rst_n,

	// command from execute
	input  logic            cmd_valid,
	input  ma_pkg::ma_cmd_t cmd,

	// writeback and sequencer
	output logic            wb_valid,
	output ma_pkg::wb_t     wb,
	output logic            busy
);

	// stage to memory
	logic             mem_req_valid;
	ma_pkg::mem_req_t mem_req;
	logic             mem_done;
	logic [31:0]      mem_rdata;

	// stage to I/O
	logic             io_we;
	logic             io_re;
	ma_pkg::io_req_t  io_req;
	logic [31:0]      io_rdata;

	ma_access_stage u_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.cmd_valid     (cmd_valid),
		.cmd           (cmd),
		.mem_req_valid (mem_req_valid),
		.mem_req       (mem_req),
		.mem_done      (mem_done),
		.mem_rdata     (mem_rdata),
		.io_we         (io_we),
		.io_re         (io_re),
		.io_req        (io_req),
		.io_rdata      (io_rdata),
		.wb_valid      (wb_valid),
		.wb            (wb),
		.busy          (busy)
	);

	data_mem_ctrl u_mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (mem_req_valid),
		.req       (mem_req),
		.done      (mem_done),
		.rdata     (mem_rdata)
	);

	io_regs u_io (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (io_we),
		.re    (io_re),
		.req   (io_req),
		.rdata (io_rdata)
	);

endmodule

// File: verification/dmem_subsys_props.sv
// protocol and timing checks for the data access subsystem
`timescale 1ns/1ns

module dmem_subsys_props (
	input logic            clk,
	input logic            rst_n,
	input logic            cmd_valid,
	input ma_pkg::ma_cmd_t cmd,
	input logic            wb_valid,
	input logic            busy
);

	int   err_count = 0;
	logic accept;
	logic io_cmd;
	logic store_open;

	assign accept = cmd_valid & ~busy;
	assign io_cmd = (cmd.addr[31:30] == ma_pkg::IO_REGION);

	// a store stays open until busy has dropped
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			store_open <= 1'b0;
		else
			store_open <= (accept & (cmd.op == ma_pkg::OP_STORE)) | (store_open & busy);
	end

	no_cmd_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
		busy |-> !cmd_valid)
	else begin
		err_count++;
		$error("command issued while busy");
	end

	no_wb_for_store: assert property (@(posedge clk) disable iff (!rst_n)
		store_open |-> !wb_valid)
	else begin
		err_count++;
		$error("writeback during a store");
	end

	pass_wb_next: assert property (@(posedge clk) disable iff (!rst_n)
		accept && cmd.op == ma_pkg::OP_PASS |=> wb_valid)
	else begin
		err_count++;
		$error("pass writeback not one cycle after the command");
	end

	io_read_wb_two: assert property (@(posedge clk) disable iff (!rst_n)
		accept && io_cmd && cmd.op == ma_pkg::OP_LOAD |=> !wb_valid ##1 wb_valid)
	else begin
		err_count++;
		$error("I/O read writeback not two cycles after the command");
	end

	// outputs quiet while reset is held
	quiet_in_reset: assert property (@(posedge clk)
		!rst_n |-> !busy && !wb_valid)
	else begin
		err_count++;
		$error("busy or writeback active during reset");
	end

endmodule

bind dmem_subsys dmem_subsys_props u_props (
	.clk       (clk),
	.rst_n     (rst_n),
	.cmd_valid (cmd_valid),
	.cmd       (cmd),
	.wb_valid  (wb_valid),
	.busy      (busy)
);

// File: verification/dmem_subsys_tb.sv
// data access subsystem testbench with LFSR stimulus checked against a shadow model
`timescale 1ns/1ns

module dmem_subsys_tb;

	// pass 4, word 16, sub-word 36, I/O 12, regions 8, reset 16
	localparam int NUM_CMDS    = 92;
	localparam int CYCLE_LIMIT = 64 * NUM_CMDS;

	logic            clk;
	logic            rst_n;
	logic            cmd_valid;
	ma_pkg::ma_cmd_t cmd;
	logic            wb_valid;
	ma_pkg::wb_t     wb;
	logic            busy;

	logic [15:0] lfsr;
	logic [31:0] shadow_mem [2**ma_pkg::MEM_ADR_BITS];
	logic [31:0] shadow_io [2**ma_pkg::IO_ADR_BITS];
	logic [31:0] io_addrs [6];
	int          errors;
	int          checks;
	int          test_errors;
	int          cycle_count;

	dmem_subsys u_dmem_subsys (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.wb_valid  (wb_valid),
		.wb        (wb),
		.busy      (busy)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic next_bit();
		logic fb;
		fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[30:0], next_bit()};
		return r;
	endfunction

	// word aligned with the top bits clear so it never hits I/O
	function automatic logic [31:0] rand_mem_addr();
		return {2'b00, 28'(rand_bits(28)), 2'b00};
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp)
		else begin
			$display("Fail %s expected %h actual %h", name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic end_test(input string name);
		if (test_errors == 0)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, test_errors);
		test_errors = 0;
	endtask

	// one-cycle strobe that returns at the falling edge after it
	task automatic send(input ma_pkg::ma_op_e op, input ma_pkg::ma_size_e size,
			input logic [4:0] rd, input logic [31:0] addr, input logic [31:0] data);
		while (busy)
			@(negedge clk);
		cmd.op      = op;
		cmd.size    = size;
		cmd.rd_adr  = rd;
		cmd.addr    = addr;
		cmd.st_data = data;
		cmd_valid   = 1'b1;
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	task automatic pass_through(input logic [31:0] value);
		logic [4:0] rd;
		rd = 5'(rand_bits(5));
		send(ma_pkg::OP_PASS, ma_pkg::SZ_WORD, rd, value, 32'h0);
		check("wb_valid", 32'h1, 32'(wb_valid));
		check("busy", 32'h0, 32'(busy));
		check("wb.data", value, wb.data);
		check("wb.rd_adr", 32'(rd), 32'(wb.rd_adr));
	endtask

	task automatic store(input ma_pkg::ma_size_e size, input logic [31:0] addr,
			input logic [31:0] data);
		logic [7:0] idx;
		logic [1:0] off;
		idx = addr[9:2];
		off = addr[1:0];
		send(ma_pkg::OP_STORE, size, 5'd0, addr, data);
		if (addr[31:30] == ma_pkg::IO_REGION)
			shadow_io[addr[5:2]] = data;
		else if (size == ma_pkg::SZ_BYTE)
			shadow_mem[idx][8*off +: 8] = data[7:0];
		else if (size == ma_pkg::SZ_HALF)
			shadow_mem[idx][16*off[1] +: 16] = data[15:0];
		else
			shadow_mem[idx] = data;
	endtask

	// waits on wb_valid and measures the latency
	task automatic load(input ma_pkg::ma_size_e size, input logic [31:0] addr);
		logic [4:0]  rd;
		logic [31:0] word;
		logic [31:0] exp;
		int          lat;
		int          cycles;
		rd = 5'(rand_bits(5));
		if (addr[31:30] == ma_pkg::IO_REGION) begin
			word = shadow_io[addr[5:2]];
			lat  = 2;
		end else begin
			word = shadow_mem[addr[9:2]];
			lat  = ma_pkg::MEM_BASE_WAIT + int'(addr[3:2]) + 1;
		end
		case (size)
			ma_pkg::SZ_BYTE: exp = {24'h0, word[8*addr[1:0] +: 8]};
			ma_pkg::SZ_HALF: exp = {16'h0, word[16*addr[1] +: 16]};
			default:         exp = word;
		endcase
		send(ma_pkg::OP_LOAD, size, rd, addr, 32'h0);
		cycles = 1;
		while (!wb_valid) begin
			@(negedge clk);
			cycles++;
		end
		check("wb.data", exp, wb.data);
		check("wb.rd_adr", 32'(rd), 32'(wb.rd_adr));
		checks++;
		assert (cycles == lat)
		else begin
			$display("writeback arrived after %0d cycles instead of %0d", cycles, lat);
			errors++;
			test_errors++;
		end
	endtask

	// may land while an access is still open
	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (2) begin
			@(negedge clk);
			check("busy", 32'h0, 32'(busy));
			check("wb_valid", 32'h0, 32'(wb_valid));
		end
		rst_n = 1'b1;
		for (int i = 0; i < 2**ma_pkg::IO_ADR_BITS; i++)
			shadow_io[i] = 32'h0;
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		logic [31:0] addr;
		logic [31:0] mem_addr;
		logic [31:0] io_addr;
		int          total;
		rst_n       = 1'b0;
		cmd_valid   = 1'b0;
		cmd         = '0;
		lfsr        = 16'd19;
		errors      = 0;
		checks      = 0;
		test_errors = 0;
		apply_reset();

		for (int i = 0; i < 4; i++)
			pass_through(rand_bits(32));
		end_test("pass-through");

		for (int i = 0; i < 8; i++) begin
			addr = rand_mem_addr();
			store(ma_pkg::SZ_WORD, addr, rand_bits(32));
			load(ma_pkg::SZ_WORD, addr);
		end
		end_test("word store and load");

		for (int i = 0; i < 6; i++) begin
			addr = rand_mem_addr();
			store(ma_pkg::SZ_WORD, addr, rand_bits(32));
			store(ma_pkg::SZ_BYTE, addr + rand_bits(2), rand_bits(32));
			store(ma_pkg::SZ_HALF, addr + (rand_bits(1) << 1), rand_bits(32));
			load(ma_pkg::SZ_BYTE, addr + rand_bits(2));
			load(ma_pkg::SZ_HALF, addr + (rand_bits(1) << 1));
			load(ma_pkg::SZ_WORD, addr);
		end
		end_test("byte and half-word lanes");

		for (int i = 0; i < 6; i++) begin
			io_addrs[i] = {2'b11, 24'(rand_bits(24)), 4'(rand_bits(4)), 2'b00};
			store(ma_pkg::SZ_WORD, io_addrs[i], rand_bits(32));
		end
		for (int i = 0; i < 6; i++)
			load(ma_pkg::SZ_WORD, io_addrs[i]);
		end_test("I/O write and read");

		// memory at 01 and at 10 shares the low bits of the I/O address
		// the first round writes memory first and the second writes I/O first
		for (int i = 0; i < 2; i++) begin
			addr     = rand_mem_addr();
			mem_addr = {(i == 0) ? 2'b01 : 2'b10, addr[29:0]};
			io_addr  = {2'b11, addr[29:0]};
			if (i == 0) begin
				store(ma_pkg::SZ_WORD, mem_addr, rand_bits(32));
				store(ma_pkg::SZ_WORD, io_addr, rand_bits(32));
			end else begin
				store(ma_pkg::SZ_WORD, io_addr, rand_bits(32));
				store(ma_pkg::SZ_WORD, mem_addr, rand_bits(32));
			end
			load(ma_pkg::SZ_WORD, mem_addr);
			load(ma_pkg::SZ_WORD, io_addr);
		end
		end_test("region separation");

		// reset lands in the writeback cycle of the last I/O read
		apply_reset();
		for (int i = 0; i < 16; i++)
			load(ma_pkg::SZ_WORD, {2'b11, 24'h0, 4'(i), 2'b00});
		end_test("reset");

		total = errors + u_dmem_subsys.u_props.err_count;
		$display("%0d checks, %0d check errors, %0d assertion failures",
			checks, errors, u_dmem_subsys.u_props.err_count);
		if (total == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: dmem_subsys.f
src/ma_pkg.sv
src/ma_access_stage.sv
src/data_mem_ctrl.sv
src/io_regs.sv
src/dmem_subsys.sv
verification/dmem_subsys_props.sv
verification/dmem_subsys_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dmem_subsys_tb
FILELIST  ?= dmem_subsys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= All tests passed

.PHONY: simulate clean

# build, run, then look for the pass line in the output
simulate:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	out=$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
